/* list.f */
verilog/lidar_point_pkg.sv
verilog/packet_cfg_pkg.sv
verilog/point_dispatch.sv
verilog/point_packer.sv
verilog/pingpong_buf.sv
verilog/packet_drain.sv
verilog/lidar_pkt_top.sv
tb/tb_clkgen.sv
tb/tb_lidar_pkt.sv

/* Makefile */
TOP = tb_lidar_pkt

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f list.f

# pass only if the pass line shows up in the output
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

/* tb/tb_lidar_pkt.sv */
`timescale 1ns/1ps

module tb_lidar_pkt
	import lidar_point_pkg::*, packet_cfg_pkg::*;
();

	// per-lane strobe spacing in cycles
	// drain serves one packet in about 34 cycles, four lanes share it
	localparam int LANE_GAP        = 40;
	localparam int RAND_POINTS     = 40;
	// directed packet, random traffic, short second loop
	localparam int TOTAL_POINTS    = PKT_POINTS + RAND_POINTS + 5;
	localparam int WATCHDOG_CYCLES = TOTAL_POINTS * 60 + 2000;

	logic       clk;
	logic       rst_n;
	logic       loop_en;
	logic       pt_stb;
	point_t     pt;
	logic       pkt_start;
	chan_t      pkt_chan;
	pcount_t    pkt_points;
	logic       byte_vld;
	logic [7:0] pkt_byte;

	integer     seed = 32'h225b;
	int         cyc = 0;
	int         next_ok [N_CHAN] = '{default: 0};
	int         value_errs = 0;
	int         other_errs = 0;
	logic       model_closed = 1'b0;

	// --------------------
	// reference model
	// --------------------
	// points of the open bank, per lane
	point_t     open_q    [N_CHAN][$];
	// closed packets waiting for the drain
	logic [7:0] exp_bytes [N_CHAN][$];
	pcount_t    exp_cnt   [N_CHAN][$];

	// monitor results, checked one edge later
	int         bytes_left;
	chan_t      mon_lane;
	logic       vld_chk = 1'b0;
	logic       vld_exp;
	logic       vld_got;
	logic       byte_chk = 1'b0;
	logic [7:0] byte_exp;
	logic [7:0] byte_got;
	logic       hdr_chk = 1'b0;
	logic       hdr_known;
	pcount_t    hdr_exp;
	pcount_t    hdr_got;

	tb_clkgen u_clkgen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	lidar_pkt_top DUT (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_loop_en    (loop_en),
		.i_pt_stb     (pt_stb),
		.i_pt         (pt),
		.o_pkt_start  (pkt_start),
		.o_pkt_chan   (pkt_chan),
		.o_pkt_points (pkt_points),
		.o_byte_vld   (byte_vld),
		.o_byte       (pkt_byte)
	);

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic report_value(input string name, input int exp_val, input int got_val);
		value_errs++;
		$display("Fail %0t %s expected %0h got %0h", $time, name, exp_val, got_val);
	endtask

	task automatic report_other(input string msg);
		other_errs++;
		$display("error at %0t: %s", $time, msg);
	endtask

	// wire order of one point, high byte first
	function automatic logic [7:0] point_byte(input point_t p, input int idx);
		case (idx)
			0:       return p.rise_time[15:8];
			1:       return p.rise_time[7:0];
			2:       return p.angle1[15:8];
			3:       return p.angle1[7:0];
			4:       return p.angle2[15:8];
			5:       return p.angle2[7:0];
			6:       return 8'h00;
			default: return 8'(p.laser_num);
		endcase
	endfunction

	function automatic point_t rand_point(input chan_t lane);
		point_t p;
		p.rise_time = 16'($random(seed));
		p.angle1    = 16'($random(seed));
		p.angle2    = 16'($random(seed));
		p.laser_num = laser_num_t'($random(seed));
		// lane sits in the low bits of the laser number
		p.laser_num[CHAN_W-1:0] = lane;
		return p;
	endfunction

	function automatic int items_pending();
		int n;
		n = 0;
		for (int k = 0; k < N_CHAN; k++) begin
			n += exp_cnt[k].size() + exp_bytes[k].size();
		end
		return n;
	endfunction

	// open bank becomes an expected packet
	task automatic close_lane(input chan_t lane);
		if (open_q[lane].size() != 0) begin
			exp_cnt[lane].push_back(pcount_t'(open_q[lane].size()));
			for (int i = 0; i < open_q[lane].size(); i++) begin
				for (int b = 0; b < BYTES_PER_POINT; b++) begin
					exp_bytes[lane].push_back(point_byte(open_q[lane][i], b));
				end
			end
			open_q[lane].delete();
			model_closed = 1'b1;
		end
	endtask

	// --------------------
	// stimulus
	// --------------------
	task automatic send_point(input point_t p);
		chan_t lane;
		lane = chan_t'(p.laser_num);
		// hold off until the lane may take another point
		while (cyc < next_ok[lane]) begin
			@(posedge clk);
		end
		pt_stb <= 1'b1;
		pt     <= p;
		next_ok[lane] = cyc + LANE_GAP;
		open_q[lane].push_back(p);
		if (open_q[lane].size() == PKT_POINTS) begin
			close_lane(lane);
		end
		@(posedge clk);
		pt_stb <= 1'b0;
	endtask

	task automatic wait_drained();
		while (items_pending() != 0) begin
			@(posedge clk);
		end
	endtask

	task automatic start_loop();
		repeat (10) @(posedge clk);
		loop_en <= 1'b1;
		repeat (4) @(posedge clk);
	endtask

	// full packets out first, then the fall closes partial banks
	task automatic end_loop();
		repeat (20) @(posedge clk);
		wait_drained();
		loop_en <= 1'b0;
		for (int k = 0; k < N_CHAN; k++) begin
			close_lane(chan_t'(k));
		end
		wait_drained();
	endtask

	initial begin
		loop_en = 1'b0;
		pt_stb  = 1'b0;
		pt      = '0;
		@(posedge rst_n);
		start_loop();
		// one full packet on lane 2
		for (int i = 0; i < PKT_POINTS; i++) begin
			send_point(rand_point(chan_t'(2)));
		end
		// interleaved traffic on random lanes
		for (int i = 0; i < RAND_POINTS; i++) begin
			repeat (1 + int'({$random(seed)} % 6)) @(posedge clk);
			send_point(rand_point(chan_t'($random(seed))));
		end
		end_loop();
		// short loop, lanes 0 and 2 get nothing
		start_loop();
		for (int i = 0; i < 3; i++) begin
			send_point(rand_point(chan_t'(1)));
			if (i < 2) begin
				send_point(rand_point(chan_t'(3)));
			end
		end
		end_loop();
		// quiet time, any late packet is a stray one
		repeat (100) @(posedge clk);
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired with %0d model entries not seen", items_pending());
		$display("** FAIL **");
		$finish;
	end

	// --------------------
	// output monitor
	// --------------------
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bytes_left <= 0;
			vld_chk    <= 1'b0;
			byte_chk   <= 1'b0;
			hdr_chk    <= 1'b0;
		end else begin
			// strobe expected exactly while bytes remain
			vld_chk  <= 1'b1;
			vld_exp  <= (bytes_left != 0);
			vld_got  <= byte_vld;
			byte_chk <= byte_vld && (bytes_left != 0);
			hdr_chk  <= pkt_start;
			if (byte_vld && bytes_left != 0) begin
				bytes_left <= bytes_left - 1;
				byte_got   <= pkt_byte;
				byte_exp   <= 8'h00;
				if (exp_bytes[mon_lane].size() != 0) begin
					byte_exp <= exp_bytes[mon_lane].pop_front();
				end
			end
			if (pkt_start) begin
				mon_lane   <= pkt_chan;
				hdr_got    <= pkt_points;
				hdr_known  <= (exp_cnt[pkt_chan].size() != 0);
				bytes_left <= BYTES_PER_POINT * int'(pkt_points);
				if (exp_cnt[pkt_chan].size() != 0) begin
					hdr_exp <= exp_cnt[pkt_chan].pop_front();
				end
			end
		end
	end

	// --------------------
	// checks
	// --------------------
	a_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!model_closed |-> (!pkt_start && !byte_vld))
		else report_other("packet output active before any packet was closed");

	a_hdr_known: assert property (@(posedge clk) hdr_chk |-> hdr_known)
		else report_other("packet header on a lane with no closed packet");

	a_hdr_points: assert property (@(posedge clk) (hdr_chk && hdr_known) |-> (hdr_got == hdr_exp))
		else report_value("o_pkt_points", int'($sampled(hdr_exp)), int'($sampled(hdr_got)));

	// no gap inside a packet and no byte outside one
	a_framing: assert property (@(posedge clk) vld_chk |-> (vld_got == vld_exp))
		else report_value("o_byte_vld", int'($sampled(vld_exp)), int'($sampled(vld_got)));

	a_byte: assert property (@(posedge clk) byte_chk |-> (byte_got == byte_exp))
		else report_value("o_byte", int'($sampled(byte_exp)), int'($sampled(byte_got)));

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
	output logic o_clk,
	output logic o_rst_n
);

	// 100 ns clock
	localparam int PERIOD_NS  = 100;
	// reset length in clock cycles
	localparam int RST_CYCLES = 10;

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// reset low from time zero, released on a rising edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

/* verilog/lidar_pkt_top.sv */
`timescale 1ns/1ps

module lidar_pkt_top
	import lidar_point_pkg::*, packet_cfg_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_loop_en,
	input  logic       i_pt_stb,
	input  point_t     i_pt,
	output logic       o_pkt_start,
	output chan_t      o_pkt_chan,
	output pcount_t    o_pkt_points,
	output logic       o_byte_vld,
	output logic [7:0] o_byte
);

	// dispatcher to lanes
	logic [N_CHAN-1:0] lane_stb;
	point_t            lane_pt;
	// lanes to drain
	bank_status_t      lane_status [N_CHAN];
	logic [7:0]        lane_rd_data [N_CHAN];
	logic [N_CHAN-1:0] lane_release;
	// shared read address from the drain
	logic              rd_bank;
	baddr_t            rd_addr;

	point_dispatch u_dispatch (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_pt_stb   (i_pt_stb),
		.i_pt       (i_pt),
		.o_lane_stb (lane_stb),
		.o_pt       (lane_pt)
	);

	// --------------------
	// channel lanes
	// --------------------
	for (genvar g = 0; g < N_CHAN; g++) begin : g_lane
		logic       wr_en;
		logic       wr_bank;
		baddr_t     wr_addr;
		logic [7:0] wr_data;

		point_packer u_packer (
			.i_clk     (i_clk),
			.i_rst_n   (i_rst_n),
			.i_loop_en (i_loop_en),
			.i_stb     (lane_stb[g]),
			.i_pt      (lane_pt),
			.i_release (lane_release[g]),
			.o_wr_en   (wr_en),
			.o_wr_bank (wr_bank),
			.o_wr_addr (wr_addr),
			.o_wr_data (wr_data),
			.o_status  (lane_status[g])
		);

		pingpong_buf u_buf (
			.i_clk     (i_clk),
			.i_wr_en   (wr_en),
			.i_wr_bank (wr_bank),
			.i_wr_addr (wr_addr),
			.i_wr_data (wr_data),
			.i_rd_bank (rd_bank),
			.i_rd_addr (rd_addr),
			.o_rd_data (lane_rd_data[g])
		);
	end

	packet_drain u_drain (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_status     (lane_status),
		.i_rd_data    (lane_rd_data),
		.o_rd_bank    (rd_bank),
		.o_rd_addr    (rd_addr),
		.o_release    (lane_release),
		.o_pkt_start  (o_pkt_start),
		.o_pkt_chan   (o_pkt_chan),
		.o_pkt_points (o_pkt_points),
		.o_byte_vld   (o_byte_vld),
		.o_byte       (o_byte)
	);

endmodule

/* verilog/packet_drain.sv */
`timescale 1ns/1ps

module packet_drain
	import lidar_point_pkg::*, packet_cfg_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  bank_status_t      i_status [N_CHAN],
	input  logic [7:0]        i_rd_data [N_CHAN],
	output logic              o_rd_bank,
	output baddr_t            o_rd_addr,
	output logic [N_CHAN-1:0] o_release,
	output logic              o_pkt_start,
	output chan_t             o_pkt_chan,
	output pcount_t           o_pkt_points,
	output logic              o_byte_vld,
	output logic [7:0]        o_byte
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HEADER,
		ST_STREAM
	} state_t;

	state_t            state;
	// lane being served, also the round-robin origin
	chan_t             cur_chan;
	pcount_t           cur_points;
	baddr_t            last_addr;
	// address was issued last cycle
	logic              rd_vld;
	logic [N_CHAN-1:0] avail;
	logic              found;
	chan_t             pick;
	chan_t             cand;

	// --------------------
	// lane selection
	// --------------------
	always_comb begin
		found = 1'b0;
		pick  = cur_chan;
		cand  = cur_chan;
		// lane in release still shows ready for one cycle
		for (int k = 0; k < N_CHAN; k++) begin
			avail[k] = i_status[k].ready & ~o_release[k];
		end
		// search starts after the last lane served
		for (int i = 1; i <= N_CHAN; i++) begin
			cand = chan_t'((cur_chan + i) % N_CHAN);
			if (!found && avail[cand]) begin
				found = 1'b1;
				pick  = cand;
			end
		end
	end

	// --------------------
	// state machine and read address
	// --------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= ST_IDLE;
			cur_chan  <= chan_t'(N_CHAN - 1);
			o_rd_addr <= '0;
			rd_vld    <= 1'b0;
			o_release <= '0;
		end else begin
			// valid trails the address by the ram latency
			rd_vld    <= (state == ST_HEADER || state == ST_STREAM);
			o_release <= '0;
			case (state)
				ST_IDLE: begin
					if (found) begin
						state     <= ST_HEADER;
						cur_chan  <= pick;
						o_rd_addr <= '0;
					end
				end
				ST_HEADER, ST_STREAM: begin
					// release goes out with the last byte
					if (o_rd_addr == last_addr) begin
						o_release[cur_chan] <= 1'b1;
						state               <= ST_IDLE;
					end else begin
						o_rd_addr <= o_rd_addr + 1'b1;
						state     <= ST_STREAM;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// packet parameters, latched with the lane
	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE && found) begin
			o_rd_bank  <= i_status[pick].bank;
			cur_points <= i_status[pick].points;
			last_addr  <= baddr_t'(i_status[pick].points * BYTES_PER_POINT - 1);
		end
	end

	assign o_pkt_start  = (state == ST_HEADER);
	assign o_pkt_chan   = cur_chan;
	assign o_pkt_points = cur_points;
	assign o_byte_vld   = rd_vld;
	assign o_byte       = i_rd_data[cur_chan];

endmodule

/* verilog/pingpong_buf.sv */
`timescale 1ns/1ps

module pingpong_buf
	import packet_cfg_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_wr_en,
	input  logic       i_wr_bank,
	input  baddr_t     i_wr_addr,
	input  logic [7:0] i_wr_data,
	input  logic       i_rd_bank,
	input  baddr_t     i_rd_addr,
	output logic [7:0] o_rd_data
);

	// --------------------
	// storage
	// --------------------

	// both banks in one array
	logic [7:0] mem [BUF_BYTES];

	// bank bit on top of the byte address
	logic [$clog2(BUF_BYTES)-1:0] wr_idx;
	logic [$clog2(BUF_BYTES)-1:0] rd_idx;

	assign wr_idx = {i_wr_bank, i_wr_addr};
	assign rd_idx = {i_rd_bank, i_rd_addr};

	// write port, packer side
	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			mem[wr_idx] <= i_wr_data;
		end
	end

	// --------------------
	// read port
	// --------------------

	// drain side, data one cycle after the address
	// reads every cycle, the drain tracks which ones count
	always_ff @(posedge i_clk) begin
		o_rd_data <= mem[rd_idx];
	end

endmodule

/* verilog/point_packer.sv */
`timescale 1ns/1ps

module point_packer
	import lidar_point_pkg::*, packet_cfg_pkg::*;
(
	input  logic         i_clk,
	input  logic         i_rst_n,
	input  logic         i_loop_en,
	input  logic         i_stb,
	input  point_t       i_pt,
	input  logic         i_release,
	output logic         o_wr_en,
	output logic         o_wr_bank,
	output baddr_t       o_wr_addr,
	output logic [7:0]   o_wr_data,
	output bank_status_t o_status
);

	// idle   loop off
	// wait   loop on, waiting for a point
	// shift  one byte per cycle into the bank
	// close  hand the bank over, flip to the other
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_SHIFT,
		ST_CLOSE
	} state_t;

	state_t              state;
	// point word, high byte goes out first
	logic [63:0]         shreg;
	logic [BCNT_W-1:0]   byte_cnt;
	baddr_t              wr_addr;
	pcount_t             pt_cnt;
	pcount_t             pt_cnt_inc;
	logic                wr_bank;
	logic                last_byte;
	logic                pkt_full;
	bank_status_t        status;

	assign last_byte  = (byte_cnt == BCNT_W'(BYTES_PER_POINT - 1));
	assign pt_cnt_inc = pt_cnt + 1'b1;
	// point in flight is the last one of the packet
	assign pkt_full   = (pt_cnt_inc == pcount_t'(PKT_POINTS));

	// --------------------
	// state machine
	// --------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_loop_en) begin
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					// loop end wins over a point in the same cycle
					if (!i_loop_en) begin
						state <= (pt_cnt != '0) ? ST_CLOSE : ST_IDLE;
					end else if (i_stb) begin
						state <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					// a started point always finishes its eight bytes
					if (last_byte) begin
						state <= pkt_full ? ST_CLOSE : ST_WAIT;
					end
				end
				ST_CLOSE: begin
					state <= i_loop_en ? ST_WAIT : ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// --------------------
	// counters
	// --------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			byte_cnt <= '0;
			wr_addr  <= '0;
			pt_cnt   <= '0;
		end else begin
			// byte index inside the current point
			byte_cnt <= (state == ST_SHIFT) ? byte_cnt + 1'b1 : '0;
			// bank address runs across the points of one packet
			if (state == ST_SHIFT) begin
				wr_addr <= wr_addr + 1'b1;
			end else if (state == ST_CLOSE || state == ST_IDLE) begin
				wr_addr <= '0;
			end
			// count a point once its last byte is written
			if (state == ST_SHIFT && last_byte) begin
				pt_cnt <= pt_cnt_inc;
			end else if (state == ST_CLOSE || state == ST_IDLE) begin
				pt_cnt <= '0;
			end
		end
	end

	// shift register, load on the strobe then drop a byte per cycle
	always_ff @(posedge i_clk) begin
		if (state == ST_WAIT && i_stb) begin
			shreg <= {i_pt.rise_time, i_pt.angle1, i_pt.angle2, 12'h000, i_pt.laser_num};
		end else if (state == ST_SHIFT) begin
			shreg <= {shreg[55:0], 8'h00};
		end
	end

	// --------------------
	// bank handover
	// --------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_bank <= 1'b0;
			status  <= '0;
		end else if (state == ST_CLOSE) begin
			// closed bank is the one just written
			status.ready  <= 1'b1;
			status.points <= pt_cnt;
			status.bank   <= wr_bank;
			wr_bank       <= ~wr_bank;
		end else if (i_release) begin
			status.ready <= 1'b0;
		end
	end

	assign o_wr_en   = (state == ST_SHIFT);
	assign o_wr_bank = wr_bank;
	assign o_wr_addr = wr_addr;
	assign o_wr_data = shreg[63:56];
	assign o_status  = status;

endmodule

/* verilog/point_dispatch.sv */
`timescale 1ns/1ps

module point_dispatch
	import lidar_point_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_pt_stb,
	input  point_t            i_pt,
	output logic [N_CHAN-1:0] o_lane_stb,
	output point_t            o_pt
);

	// --------------------
	// lane decode
	// --------------------

	// lane number, low bits of the laser number
	chan_t             lane;
	// one-hot strobe before the register
	logic [N_CHAN-1:0] lane_stb_nxt;

	// truncating cast keeps the low bits
	assign lane = chan_t'(i_pt.laser_num);

	always_comb begin
		lane_stb_nxt = '0;
		// only the addressed lane sees the strobe
		if (i_pt_stb) begin
			lane_stb_nxt[lane] = 1'b1;
		end
	end

	// --------------------
	// output registers
	// --------------------

	// strobe vector, one cycle after the input strobe
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_lane_stb <= '0;
		end else begin
			o_lane_stb <= lane_stb_nxt;
		end
	end

	// point capture
	// held until the next strobe so every lane
	// can load it in the strobe cycle
	always_ff @(posedge i_clk) begin
		if (i_pt_stb) begin
			o_pt <= i_pt;
		end
	end

endmodule

/* verilog/packet_cfg_pkg.sv */
package packet_cfg_pkg;

	// small point count of a full packet
	localparam int PKT_POINTS = 4;

	// bytes one point takes in a bank
	localparam int BYTES_PER_POINT = 8;

	// byte counter width inside one point
	localparam int BCNT_W = $clog2(BYTES_PER_POINT);

	// one bank holds exactly one full packet
	localparam int BANK_BYTES = PKT_POINTS * BYTES_PER_POINT;

	// two banks per lane buffer
	localparam int BUF_BYTES = 2 * BANK_BYTES;

	// byte address within a bank
	typedef logic [$clog2(BANK_BYTES)-1:0] baddr_t;

	// point count that has to reach PKT_POINTS itself
	typedef logic [$clog2(PKT_POINTS+1)-1:0] pcount_t;

	// closed bank as seen by the drain
	// ready holds until the drain releases it
	typedef struct packed {
		logic    ready;
		pcount_t points;
		logic    bank;
	} bank_status_t;

endpackage

/* verilog/lidar_point_pkg.sv */
package lidar_point_pkg;

	// number of channel lanes
	localparam int N_CHAN = 4;

	// laser number coming from the tdc
	localparam int LASER_W = 4;

	// lane index width follows the lane count
	localparam int CHAN_W = $clog2(N_CHAN);

	// --------------------
	// scalar types
	// --------------------

	// laser number whose low bits pick the lane
	typedef logic [LASER_W-1:0] laser_num_t;

	// lane index
	typedef logic [CHAN_W-1:0] chan_t;

	// --------------------
	// point record
	// --------------------

	// one shot as sampled at the strobe
	// rise time first and laser number last
	typedef struct packed {
		// tdc rise time
		logic [15:0] rise_time;
		// encoder angle of the first axis
		logic [15:0] angle1;
		// encoder angle of the second axis
		logic [15:0] angle2;
		// laser that fired
		laser_num_t  laser_num;
	} point_t;

endpackage
